/* Bender.yml */
package:
  name: llc_front

sources:
  - logic/llc_pkg.sv
  - logic/llc_chan_buf.sv
  - logic/llc_stall_ctrl.sv
  - logic/llc_input_decoder.sv
  - logic/llc_front_top.sv
  - target: test
    files:
      - dv/llc_clk_gen.sv
      - dv/llc_front_tb.sv

/* dv/llc_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module llc_clk_gen (
    output logic clk,
    output logic rst
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // held low over the first 8 rising edges
    initial begin
        rst = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b1;
    end

endmodule

`default_nettype wire

/* dv/llc_front_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module llc_front_tb
    import llc_pkg::*;
();

    localparam int test_count      = 6;
    localparam int cycles_per_test = 200;
    localparam int watchdog_cycles = test_count * cycles_per_test + 400;

    logic      clk;
    logic      rst;
    logic      rsp_in_valid;
    logic      rsp_in_ready;
    rsp_pkt_t  rsp_in;
    logic      req_in_valid;
    logic      req_in_ready;
    req_pkt_t  req_in;
    logic      dma_in_valid;
    logic      dma_in_ready;
    dma_pkt_t  dma_in;
    logic      rst_tb_valid;
    logic      rst_tb_ready;
    logic      flush_req;
    logic      look_valid;
    logic      look_ready;
    look_cmd_t look;

    integer    seed;
    int        error_count;
    string     test_name;
    look_cmd_t exp_q[$];
    look_cmd_t exp_head;
    logic      bp_on;
    req_pkt_t  bp_reqs[10];
    dma_pkt_t  bp_dmas[6];

    // reference model of the miss tracking
    logic       model_out_valid;
    line_addr_t model_out_addr;
    logic       model_stall;
    req_pkt_t   model_stalled;

    llc_clk_gen i_llc_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    llc_front_top i_llc_front_top (
        .clk          (clk),
        .rst          (rst),
        .rsp_in_valid (rsp_in_valid),
        .rsp_in_ready (rsp_in_ready),
        .rsp_in       (rsp_in),
        .req_in_valid (req_in_valid),
        .req_in_ready (req_in_ready),
        .req_in       (req_in),
        .dma_in_valid (dma_in_valid),
        .dma_in_ready (dma_in_ready),
        .dma_in       (dma_in),
        .rst_tb_valid (rst_tb_valid),
        .rst_tb_ready (rst_tb_ready),
        .flush_req    (flush_req),
        .look_valid   (look_valid),
        .look_ready   (look_ready),
        .look         (look)
    );

    task automatic stop_run();
        error_count++;
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_error(input string msg);
        $display("ERROR in %s: %s", test_name, msg);
        stop_run();
    endtask

    task automatic report_mismatch(input look_cmd_t exp, input look_cmd_t act);
        $display("MISMATCH %s: expected %h actual %h", test_name, exp, act);
        stop_run();
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // set is the low bits of the line, tag the rest
    function automatic look_cmd_t make_look(input look_kind_t kind, input line_addr_t addr,
                                            input logic [1:0] op);
        look_cmd_t c;
        c.kind        = kind;
        c.line_br.set = addr[llc_set_bits-1:0];
        c.line_br.tag = addr[llc_line_bits-1:llc_set_bits];
        c.op          = op;
        return c;
    endfunction

    // random line that is not the open miss
    function automatic line_addr_t fresh_line();
        line_addr_t a;
        a = line_addr_t'($random(seed));
        if (model_out_valid && a == model_out_addr) begin
            a = a ^ line_addr_t'(1);
        end
        return a;
    endfunction

    task automatic expect_sweep(input look_kind_t kind);
        for (int s = 0; s < llc_sets; s++) begin
            exp_q.push_back(make_look(kind, line_addr_t'(s), 2'b00));
        end
    endtask

    task automatic expect_req(input req_pkt_t p);
        if (model_out_valid && p.addr == model_out_addr) begin
            model_stall   = 1'b1;
            model_stalled = p;
        end else begin
            exp_q.push_back(make_look(look_req, p.addr, p.op));
            model_out_valid = 1'b1;
            model_out_addr  = p.addr;
        end
    endtask

    // a hit on the open miss releases the stalled req right behind it
    task automatic expect_rsp(input rsp_pkt_t p);
        exp_q.push_back(make_look(look_rsp, p.addr, p.rsp_type));
        if (model_out_valid && p.addr == model_out_addr) begin
            model_out_valid = 1'b0;
            if (model_stall) begin
                model_stall = 1'b0;
                expect_req(model_stalled);
            end
        end
    endtask

    task automatic expect_dma(input dma_pkt_t p);
        exp_q.push_back(make_look(look_dma, p.addr, 2'b00));
    endtask

    task automatic send_rsp(input rsp_pkt_t p);
        rsp_in       = p;
        rsp_in_valid = 1'b1;
        while (!rsp_in_ready) next_cycle();
        next_cycle();
        rsp_in_valid = 1'b0;
        assert (!rsp_in_ready) else report_error("rsp_in_ready still high after a fill");
    endtask

    task automatic send_req(input req_pkt_t p);
        req_in       = p;
        req_in_valid = 1'b1;
        while (!req_in_ready) next_cycle();
        next_cycle();
        req_in_valid = 1'b0;
        assert (!req_in_ready) else report_error("req_in_ready still high after a fill");
    endtask

    task automatic send_dma(input dma_pkt_t p);
        dma_in       = p;
        dma_in_valid = 1'b1;
        while (!dma_in_ready) next_cycle();
        next_cycle();
        dma_in_valid = 1'b0;
        assert (!dma_in_ready) else report_error("dma_in_ready still high after a fill");
    endtask

    task automatic send_rst_tb();
        rst_tb_valid = 1'b1;
        while (!rst_tb_ready) next_cycle();
        next_cycle();
        rst_tb_valid = 1'b0;
        assert (!rst_tb_ready) else report_error("rst_tb_ready still high after a fill");
    endtask

    // wait out the queue, then leave room for any stray look
    task automatic drain();
        while (exp_q.size() != 0) next_cycle();
        repeat (6) next_cycle();
    endtask

    // valid and ready are stable here and the transfer lands on the next edge
    always @(negedge clk) begin
        if (rst && look_valid && look_ready) begin
            assert (exp_q.size() != 0)
                else report_error($sformatf("unexpected look command %h", look));
            if (exp_q.size() != 0) begin
                exp_head = exp_q.pop_front();
                assert (look == exp_head) else report_mismatch(exp_head, look);
            end
        end
    end

    always @(posedge clk) begin
        if (bp_on) begin
            #1;
            look_ready = 1'($random(seed));
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        report_error($sformatf("watchdog expired after %0d cycles", watchdog_cycles));
    end

    initial begin
        rsp_pkt_t r;
        req_pkt_t q;
        req_pkt_t q2;
        req_pkt_t qb;
        dma_pkt_t d;
        seed            = 32'hbcd6_4d49;
        error_count     = 0;
        test_name       = "reset";
        bp_on           = 1'b0;
        model_out_valid = 1'b0;
        model_out_addr  = '0;
        model_stall     = 1'b0;
        model_stalled   = '0;
        rsp_in_valid    = 1'b0;
        rsp_in          = '0;
        req_in_valid    = 1'b0;
        req_in          = '0;
        dma_in_valid    = 1'b0;
        dma_in          = '0;
        rst_tb_valid    = 1'b0;
        flush_req       = 1'b0;
        look_ready      = 1'b1;
        wait (rst === 1'b1);
        assert (!look_valid && !rsp_in_ready && !req_in_ready && !dma_in_ready)
            else report_error("outputs not idle right after reset");

        test_name = "reset_sweep";
        q.addr  = fresh_line();
        q.op    = 2'($random(seed));
        d.addr  = line_addr_t'($random(seed));
        d.write = 1'($random(seed));
        expect_sweep(look_rst);
        expect_req(q);
        expect_dma(d);
        fork
            send_req(q);
            send_dma(d);
        join
        drain();
        expect_sweep(look_rst);
        send_rst_tb();
        drain();

        test_name  = "priority";
        look_ready = 1'b0;
        d.addr     = line_addr_t'($random(seed));
        d.write    = 1'($random(seed));
        expect_dma(d);
        send_dma(d);
        while (!look_valid) next_cycle();
        r.addr     = line_addr_t'($random(seed));
        r.rsp_type = 2'($random(seed));
        q.addr     = fresh_line();
        q.op       = 2'($random(seed));
        d.addr     = line_addr_t'($random(seed));
        d.write    = 1'($random(seed));
        expect_rsp(r);
        expect_req(q);
        expect_dma(d);
        fork
            send_rsp(r);
            send_req(q);
            send_dma(d);
        join
        repeat (3) next_cycle();
        look_ready = 1'b1;
        drain();

        test_name = "addr_breakdown";
        for (int i = 0; i < 6; i++) begin
            q.addr = fresh_line();
            q.op   = 2'($random(seed));
            expect_req(q);
            send_req(q);
            drain();
            r.addr     = line_addr_t'($random(seed));
            r.rsp_type = 2'($random(seed));
            expect_rsp(r);
            send_rsp(r);
            drain();
            d.addr  = line_addr_t'($random(seed));
            d.write = 1'($random(seed));
            expect_dma(d);
            send_dma(d);
            drain();
        end

        test_name = "miss_stall";
        q.addr = fresh_line();
        q.op   = 2'($random(seed));
        expect_req(q);
        send_req(q);
        drain();
        // same line again, held back until the response
        q2.addr = q.addr;
        q2.op   = ~q.op;
        expect_req(q2);
        send_req(q2);
        repeat (12) next_cycle();
        d.addr  = line_addr_t'($random(seed));
        d.write = 1'($random(seed));
        qb.addr = fresh_line();
        qb.op   = 2'($random(seed));
        fork
            send_dma(d);
            send_req(qb);
        join
        repeat (20) next_cycle();
        r.addr     = q.addr;
        r.rsp_type = 2'($random(seed));
        expect_rsp(r);
        expect_req(qb);
        expect_dma(d);
        send_rsp(r);
        drain();

        test_name = "flush";
        flush_req = 1'b1;
        next_cycle();
        flush_req = 1'b0;
        repeat (2) next_cycle();
        r.addr     = line_addr_t'($random(seed));
        r.rsp_type = 2'($random(seed));
        q.addr     = fresh_line();
        q.op       = 2'($random(seed));
        expect_sweep(look_flush);
        expect_rsp(r);
        expect_req(q);
        fork
            send_rsp(r);
            send_req(q);
        join
        drain();

        test_name  = "back_pressure";
        look_ready = 1'b0;
        d.addr     = line_addr_t'($random(seed));
        d.write    = 1'($random(seed));
        expect_dma(d);
        send_dma(d);
        while (!look_valid) next_cycle();
        q.addr = fresh_line();
        q.op   = 2'($random(seed));
        expect_req(q);
        send_req(q);
        repeat (5) begin
            next_cycle();
            assert (!req_in_ready) else report_error("req_in_ready high while its buffer is full");
        end
        for (int i = 0; i < 10; i++) begin
            bp_reqs[i].addr = fresh_line();
            bp_reqs[i].op   = 2'($random(seed));
            expect_req(bp_reqs[i]);
        end
        for (int i = 0; i < 6; i++) begin
            bp_dmas[i].addr  = line_addr_t'($random(seed));
            bp_dmas[i].write = 1'($random(seed));
            expect_dma(bp_dmas[i]);
        end
        bp_on = 1'b1;
        for (int i = 0; i < 10; i++) begin
            send_req(bp_reqs[i]);
        end
        for (int i = 0; i < 6; i++) begin
            send_dma(bp_dmas[i]);
        end
        bp_on = 1'b0;
        next_cycle();
        look_ready = 1'b1;
        drain();

        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* logic/llc_chan_buf.sv */
`timescale 1ns/1ps
`default_nettype none

module llc_chan_buf #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     buf_valid,
    output payload_t buf_data,
    input  logic     take
);

    logic accept;
    logic full_next;

    assign accept = in_valid && in_ready;

    // occupancy after this edge
    always_comb begin
        full_next = buf_valid;
        if (take && buf_valid) begin
            full_next = 1'b0;
        end
        if (accept) begin
            full_next = 1'b1;
        end
    end

    // ready is registered from the next occupancy, so it
    // falls right after a fill and rises right after a take
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            buf_valid <= 1'b0;
            in_ready  <= 1'b0;
        end else begin
            buf_valid <= full_next;
            in_ready  <= !full_next;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            buf_data <= in_data;
        end
    end

endmodule

`default_nettype wire

/* logic/llc_front_top.sv */
`timescale 1ns/1ps
`default_nettype none

module llc_front_top
    import llc_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      rsp_in_valid,
    output logic      rsp_in_ready,
    input  rsp_pkt_t  rsp_in,
    input  logic      req_in_valid,
    output logic      req_in_ready,
    input  req_pkt_t  req_in,
    input  logic      dma_in_valid,
    output logic      dma_in_ready,
    input  dma_pkt_t  dma_in,
    input  logic      rst_tb_valid,
    output logic      rst_tb_ready,
    input  logic      flush_req,
    output logic      look_valid,
    input  logic      look_ready,
    output look_cmd_t look
);

    logic      rsp_valid;
    logic      req_valid;
    logic      dma_valid;
    logic      rst_tb_buf_valid;
    rsp_pkt_t  rsp_data;
    req_pkt_t  req_data;
    dma_pkt_t  dma_data;
    logic      rst_tb_data;
    logic      rsp_take;
    logic      req_take;
    logic      dma_take;
    logic      rst_tb_take;
    logic      out_free;
    logic      look_wr;
    look_cmd_t look_cmd;

    logic      rst_stall;
    logic      flush_stall;
    logic      req_stall;
    logic      stalled_valid;
    llc_set_t  sweep_set;
    req_pkt_t  stalled_req;
    logic      outstanding_valid;
    line_br_t  outstanding;
    req_pkt_t  new_stalled_req;
    line_br_t  new_outstanding;
    logic      incr_sweep_set;
    logic      clr_rst_stall;
    logic      clr_flush_stall;
    logic      set_req_stall;
    logic      clr_req_stall;
    logic      take_stalled;
    logic      set_outstanding;
    logic      clr_outstanding;

    llc_chan_buf #(.payload_t(rsp_pkt_t)) i_rsp_buf (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (rsp_in_valid),
        .in_ready  (rsp_in_ready),
        .in_data   (rsp_in),
        .buf_valid (rsp_valid),
        .buf_data  (rsp_data),
        .take      (rsp_take)
    );

    llc_chan_buf #(.payload_t(req_pkt_t)) i_req_buf (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (req_in_valid),
        .in_ready  (req_in_ready),
        .in_data   (req_in),
        .buf_valid (req_valid),
        .buf_data  (req_data),
        .take      (req_take)
    );

    llc_chan_buf #(.payload_t(dma_pkt_t)) i_dma_buf (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (dma_in_valid),
        .in_ready  (dma_in_ready),
        .in_data   (dma_in),
        .buf_valid (dma_valid),
        .buf_data  (dma_data),
        .take      (dma_take)
    );

    // rst_tb carries only a marker bit
    llc_chan_buf #(.payload_t(logic)) i_rst_tb_buf (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (rst_tb_valid),
        .in_ready  (rst_tb_ready),
        .in_data   (1'b1),
        .buf_valid (rst_tb_buf_valid),
        .buf_data  (rst_tb_data),
        .take      (rst_tb_take)
    );

    llc_chan_buf #(.payload_t(look_cmd_t)) i_look_buf (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (look_wr),
        .in_ready  (out_free),
        .in_data   (look_cmd),
        .buf_valid (look_valid),
        .buf_data  (look),
        .take      (look_ready && look_valid)
    );

    llc_stall_ctrl i_stall_ctrl (
        .clk               (clk),
        .rst               (rst),
        .flush_req         (flush_req),
        .incr_sweep_set    (incr_sweep_set),
        .clr_rst_stall     (clr_rst_stall),
        .clr_flush_stall   (clr_flush_stall),
        .rst_tb_taken      (rst_tb_take),
        .set_req_stall     (set_req_stall),
        .clr_req_stall     (clr_req_stall),
        .take_stalled      (take_stalled),
        .set_outstanding   (set_outstanding),
        .clr_outstanding   (clr_outstanding),
        .new_stalled_req   (new_stalled_req),
        .new_outstanding   (new_outstanding),
        .rst_stall         (rst_stall),
        .flush_stall       (flush_stall),
        .req_stall         (req_stall),
        .stalled_valid     (stalled_valid),
        .sweep_set         (sweep_set),
        .stalled_req       (stalled_req),
        .outstanding_valid (outstanding_valid),
        .outstanding       (outstanding)
    );

    llc_input_decoder i_input_decoder (
        .clk               (clk),
        .rst               (rst),
        .rsp_valid         (rsp_valid),
        .rsp_data          (rsp_data),
        .rsp_take          (rsp_take),
        .req_valid         (req_valid),
        .req_data          (req_data),
        .req_take          (req_take),
        .dma_valid         (dma_valid),
        .dma_data          (dma_data),
        .dma_take          (dma_take),
        .rst_tb_valid      (rst_tb_buf_valid),
        .rst_tb_data       (rst_tb_data),
        .rst_tb_take       (rst_tb_take),
        .out_free          (out_free),
        .look_wr           (look_wr),
        .look_cmd          (look_cmd),
        .rst_stall         (rst_stall),
        .flush_stall       (flush_stall),
        .req_stall         (req_stall),
        .sweep_set         (sweep_set),
        .stalled_valid     (stalled_valid),
        .stalled_req       (stalled_req),
        .outstanding_valid (outstanding_valid),
        .outstanding       (outstanding),
        .incr_sweep_set    (incr_sweep_set),
        .clr_rst_stall     (clr_rst_stall),
        .clr_flush_stall   (clr_flush_stall),
        .set_req_stall     (set_req_stall),
        .clr_req_stall     (clr_req_stall),
        .take_stalled      (take_stalled),
        .set_outstanding   (set_outstanding),
        .clr_outstanding   (clr_outstanding),
        .new_stalled_req   (new_stalled_req),
        .new_outstanding   (new_outstanding)
    );

endmodule

`default_nettype wire

/* logic/llc_input_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module llc_input_decoder
    import llc_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      rsp_valid,
    input  rsp_pkt_t  rsp_data,
    output logic      rsp_take,
    input  logic      req_valid,
    input  req_pkt_t  req_data,
    output logic      req_take,
    input  logic      dma_valid,
    input  dma_pkt_t  dma_data,
    output logic      dma_take,
    input  logic      rst_tb_valid,
    input  logic      rst_tb_data,
    output logic      rst_tb_take,
    input  logic      out_free,
    output logic      look_wr,
    output look_cmd_t look_cmd,
    input  logic      rst_stall,
    input  logic      flush_stall,
    input  logic      req_stall,
    input  llc_set_t  sweep_set,
    input  logic      stalled_valid,
    input  req_pkt_t  stalled_req,
    input  logic      outstanding_valid,
    input  line_br_t  outstanding,
    output logic      incr_sweep_set,
    output logic      clr_rst_stall,
    output logic      clr_flush_stall,
    output logic      set_req_stall,
    output logic      clr_req_stall,
    output logic      take_stalled,
    output logic      set_outstanding,
    output logic      clr_outstanding,
    output req_pkt_t  new_stalled_req,
    output line_br_t  new_outstanding
);

    typedef enum logic [1:0] {
        st_idle,
        st_decode,
        st_set,
        st_stall
    } state_t;

    state_t state;
    state_t next_state;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    // idle holds until the output buffer has room
    always_comb begin
        next_state = state;
        case (state)
            st_idle:   if (out_free) next_state = st_decode;
            st_decode: next_state = st_set;
            st_set:    next_state = st_stall;
            default:   next_state = st_idle;
        endcase
    end

    logic can_get_rsp;
    logic can_get_req;
    logic can_get_dma;
    logic can_get_rst_tb;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            can_get_rsp    <= 1'b0;
            can_get_req    <= 1'b0;
            can_get_dma    <= 1'b0;
            can_get_rst_tb <= 1'b0;
        end else begin
            can_get_rsp    <= rsp_valid;
            can_get_req    <= req_valid;
            can_get_dma    <= dma_valid;
            can_get_rst_tb <= rst_tb_valid && rst_tb_data;
        end
    end

    logic [7:0] sel_next;
    logic [7:0] sel;
    line_addr_t addr_sel;
    logic [1:0] op_sel;
    logic       req_hit;
    line_br_t   line_br_q;
    logic [1:0] op_q;

    // sel bit 0 rst sweep, 1 flush sweep, 2 rst_tb, 3 rsp,
    // 4 stalled req, 5 req issue, 6 req to stall, 7 dma
    assign req_hit = outstanding_valid
                     && (req_data.addr == {outstanding.tag, outstanding.set});

    always_comb begin
        sel_next = '0;
        addr_sel = '0;
        op_sel   = '0;
        if (rst_stall) begin
            sel_next[0] = 1'b1;
            addr_sel    = line_addr_t'(sweep_set);
        end else if (flush_stall) begin
            sel_next[1] = 1'b1;
            addr_sel    = line_addr_t'(sweep_set);
        end else if (can_get_rst_tb) begin
            sel_next[2] = 1'b1;
        end else if (can_get_rsp) begin
            sel_next[3] = 1'b1;
            addr_sel    = rsp_data.addr;
            op_sel      = rsp_data.rsp_type;
        end else if (!req_stall && stalled_valid) begin
            sel_next[4] = 1'b1;
            addr_sel    = stalled_req.addr;
            op_sel      = stalled_req.op;
        end else if (!req_stall && can_get_req) begin
            // same line as the open miss waits for its response
            sel_next[5] = !req_hit;
            sel_next[6] = req_hit;
            addr_sel    = req_data.addr;
            op_sel      = req_data.op;
        end else if (!req_stall && can_get_dma) begin
            sel_next[7] = 1'b1;
            addr_sel    = dma_data.addr;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            sel <= '0;
        end else if (state == st_decode) begin
            sel <= sel_next;
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_decode) begin
            line_br_q.tag <= addr_sel[llc_line_bits-1:llc_set_bits];
            line_br_q.set <= addr_sel[llc_set_bits-1:0];
            op_q          <= op_sel;
        end
    end

    // set state
    assign rsp_take     = (state == st_set) && sel[3];
    assign take_stalled = (state == st_set) && sel[4];
    assign req_take     = (state == st_set) && (sel[5] || sel[6]);
    assign dma_take     = (state == st_set) && sel[7];
    assign rst_tb_take  = (state == st_set) && sel[2];
    assign look_wr      = (state == st_set) && (|{sel[7], sel[5:3], sel[1:0]});

    always_comb begin
        look_cmd.line_br = line_br_q;
        look_cmd.op      = op_q;
        if (sel[0]) begin
            look_cmd.kind = look_rst;
        end else if (sel[1]) begin
            look_cmd.kind = look_flush;
        end else if (sel[3]) begin
            look_cmd.kind = look_rsp;
        end else if (sel[7]) begin
            look_cmd.kind = look_dma;
        end else begin
            look_cmd.kind = look_req;
        end
    end

    // stall state
    logic last_set;
    logic rsp_hit;

    assign last_set = (sweep_set == llc_set_t'(llc_sets - 1));
    assign rsp_hit  = sel[3] && outstanding_valid && (line_br_q == outstanding);

    assign incr_sweep_set  = (state == st_stall) && (sel[0] || sel[1]);
    assign clr_rst_stall   = (state == st_stall) && sel[0] && last_set;
    assign clr_flush_stall = (state == st_stall) && sel[1] && last_set;
    assign set_req_stall   = (state == st_stall) && sel[6];
    assign set_outstanding = (state == st_stall) && (sel[4] || sel[5]);
    assign clr_outstanding = (state == st_stall) && rsp_hit;
    assign clr_req_stall   = (state == st_stall) && rsp_hit;

    assign new_stalled_req.addr = {line_br_q.tag, line_br_q.set};
    assign new_stalled_req.op   = op_q;
    assign new_outstanding      = line_br_q;

endmodule

`default_nettype wire

/* logic/llc_pkg.sv */
`default_nettype none

package llc_pkg;

    // line address split
    localparam int llc_line_bits = 28;
    localparam int llc_set_bits  = 4;
    localparam int llc_tag_bits  = llc_line_bits - llc_set_bits;
    localparam int llc_sets      = 1 << llc_set_bits;

    typedef logic [llc_line_bits-1:0] line_addr_t;
    typedef logic [llc_set_bits-1:0]  llc_set_t;
    typedef logic [llc_tag_bits-1:0]  llc_tag_t;

    // set sits in the low bits so a plain cast from line_addr_t works
    typedef struct packed {
        llc_tag_t tag;
        llc_set_t set;
    } line_br_t;

    // cpu request, also the stalled request
    typedef struct packed {
        line_addr_t addr;
        logic [1:0] op;
    } req_pkt_t;

    // coherence response
    typedef struct packed {
        line_addr_t addr;
        logic [1:0] rsp_type;
    } rsp_pkt_t;

    typedef struct packed {
        line_addr_t addr;
        logic       write;
    } dma_pkt_t;

    typedef enum logic [2:0] {
        look_rst,
        look_flush,
        look_rsp,
        look_req,
        look_dma
    } look_kind_t;

    // op is zero for sweep and dma looks
    typedef struct packed {
        look_kind_t kind;
        line_br_t   line_br;
        logic [1:0] op;
    } look_cmd_t;

endpackage

`default_nettype wire

/* logic/llc_stall_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module llc_stall_ctrl
    import llc_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     flush_req,
    input  logic     incr_sweep_set,
    input  logic     clr_rst_stall,
    input  logic     clr_flush_stall,
    input  logic     rst_tb_taken,
    input  logic     set_req_stall,
    input  logic     clr_req_stall,
    input  logic     take_stalled,
    input  logic     set_outstanding,
    input  logic     clr_outstanding,
    input  req_pkt_t new_stalled_req,
    input  line_br_t new_outstanding,
    output logic     rst_stall,
    output logic     flush_stall,
    output logic     req_stall,
    output logic     stalled_valid,
    output llc_set_t sweep_set,
    output req_pkt_t stalled_req,
    output logic     outstanding_valid,
    output line_br_t outstanding
);

    logic flush_pend;
    logic flush_start;

    // flush waits until no sweep is running
    assign flush_start = flush_pend && !rst_stall && !flush_stall;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rst_stall   <= 1'b1;
            flush_stall <= 1'b0;
            flush_pend  <= 1'b0;
            sweep_set   <= '0;
        end else begin
            flush_pend <= flush_req || (flush_pend && !flush_start);
            if (rst_tb_taken) begin
                rst_stall <= 1'b1;
            end else if (clr_rst_stall) begin
                rst_stall <= 1'b0;
            end
            if (flush_start) begin
                flush_stall <= 1'b1;
            end else if (clr_flush_stall) begin
                flush_stall <= 1'b0;
            end
            // wraps back to 0 after set 15
            if (rst_tb_taken || flush_start) begin
                sweep_set <= '0;
            end else if (incr_sweep_set) begin
                sweep_set <= sweep_set + llc_set_t'(1);
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            req_stall         <= 1'b0;
            stalled_valid     <= 1'b0;
            outstanding_valid <= 1'b0;
        end else begin
            if (set_req_stall) begin
                req_stall     <= 1'b1;
                stalled_valid <= 1'b1;
            end else begin
                if (clr_req_stall) begin
                    req_stall <= 1'b0;
                end
                if (take_stalled) begin
                    stalled_valid <= 1'b0;
                end
            end
            if (set_outstanding) begin
                outstanding_valid <= 1'b1;
            end else if (clr_outstanding) begin
                outstanding_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (set_req_stall) begin
            stalled_req <= new_stalled_req;
        end
        if (set_outstanding) begin
            outstanding <= new_outstanding;
        end
    end

endmodule

`default_nettype wire

/* sources.f */
logic/llc_pkg.sv
logic/llc_chan_buf.sv
logic/llc_stall_ctrl.sv
logic/llc_input_decoder.sv
logic/llc_front_top.sv
dv/llc_clk_gen.sv
dv/llc_front_tb.sv
